// File: mips_loader_top.f
+incdir+include
design/loader_pkg.sv
design/core_ctrl_if.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/program_memory.sv
design/fetch_unit.sv
design/mips_loader_top.sv
test/mips_loader_asserts.sv
test/tb_mips_loader_top.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_mips_loader_top
FILELIST  := mips_loader_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Test passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_mips_loader_top.sv
`timescale 1ns/1ps
`include "loader_defs.svh"

module tb_mips_loader_top
  import loader_pkg::*;
();

  localparam int   SEED         = 15;
  localparam int   TX_TIMEOUT   = 400;  // Cycles to wait for a start bit.
  localparam int   RUN_TIMEOUT  = 400;  // Cycles to wait for o_running.
  localparam int   QUIET_CYCLES = 200;  // Longer than one full frame.
  localparam int   BIT_CLKS     = `LOADER_CLKS_PER_BIT;
  localparam byte_t IDLE_BYTE   = 8'h05;  // Not a command in idle.
  localparam byte_t BAD_START   = 8'h02;  // Not a start command.
  localparam byte_t STEP_BYTE   = 8'h55;  // Never a soft reset.

  logic         i_clock;
  logic         i_reset;
  logic         i_uart_rx;
  logic         o_uart_tx;
  logic         o_led;
  mem_addr_t    o_pc;
  instruction_t o_instruction;
  logic         o_running;

  instruction_t program_words[$];  // Last entry is the halt word.

  mips_loader_top i_mips_loader_top (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_uart_rx     (i_uart_rx),
    .o_uart_tx     (o_uart_tx),
    .o_led         (o_led),
    .o_pc          (o_pc),
    .o_instruction (o_instruction),
    .o_running     (o_running)
  );

  initial begin
    i_clock = 1'b0;
    forever #5 i_clock = ~i_clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks.
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_byte(input string name, input byte_t got, input byte_t expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                          $time, name, got, expected));
    end
  endtask

  task automatic compare_instruction(input string name, input instruction_t got,
                                     input instruction_t expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                          $time, name, got, expected));
    end
  endtask

  task automatic compare_addr(input string name, input mem_addr_t got,
                              input mem_addr_t expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                          $time, name, got, expected));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                          $time, name, got, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side UART model.
  //////////////////////////////////////////////////////////////////////

  task automatic send_byte(input byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};  // Stop, data LSB first, start.
    for (int i = 0; i < 10; i++) begin
      @(posedge i_clock);
      #1 i_uart_rx = frame[i];
      repeat (BIT_CLKS - 1) @(posedge i_clock);
    end
  endtask

  task automatic receive_byte(output byte_t value);
    int waited;
    waited = 0;
    @(negedge i_clock);
    while (o_uart_tx !== 1'b0) begin
      if (waited == TX_TIMEOUT) begin
        abort_run("Timeout: no start bit appeared on o_uart_tx");
      end
      waited++;
      @(negedge i_clock);
    end
    repeat (BIT_CLKS / 2) @(negedge i_clock);  // Middle of the start bit.
    compare_bit("o_uart_tx start bit", o_uart_tx, 1'b0);
    for (int i = 0; i < `LOADER_BYTE_BITS; i++) begin
      repeat (BIT_CLKS) @(negedge i_clock);
      value[i] = o_uart_tx;
    end
    repeat (BIT_CLKS) @(negedge i_clock);
    compare_bit("o_uart_tx stop bit", o_uart_tx, 1'b1);
  endtask

  task automatic send_word(input instruction_t word);
    for (int b = 3; b >= 0; b--) begin
      send_byte(word[b*`LOADER_BYTE_BITS +: `LOADER_BYTE_BITS]);  // MSB first.
    end
  endtask

  task automatic load_program();
    int           count;
    instruction_t word;
    program_words.delete();
    count = 6 + ($urandom % 5);
    for (int i = 0; i <= count; i++) begin
      word = (i == count) ? '0 : instruction_t'($urandom);
      if (i < count && word == '0) begin
        word = instruction_t'(1);  // Only the last word may halt.
      end
      program_words.push_back(word);
      send_word(word);
    end
  endtask

  task automatic wait_running(input logic level);
    int waited;
    waited = 0;
    @(negedge i_clock);
    while (o_running !== level) begin
      if (waited == RUN_TIMEOUT) begin
        abort_run($sformatf("Timeout: o_running never became %b", level));
      end
      waited++;
      @(negedge i_clock);
    end
  endtask

  task automatic check_not_running(input int cycles);
    repeat (cycles) begin
      @(negedge i_clock);
      compare_bit("o_running", o_running, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests.
  //////////////////////////////////////////////////////////////////////

  task automatic test_after_reset();
    @(negedge i_clock);
    compare_bit("o_uart_tx", o_uart_tx, 1'b1);
    compare_bit("o_led", o_led, 1'b1);
    compare_bit("o_running", o_running, 1'b0);
  endtask

  task automatic test_idle_ignore();
    fork
      send_byte(IDLE_BYTE);
      repeat (QUIET_CYCLES) begin
        @(negedge i_clock);
        if (o_uart_tx !== 1'b1) begin
          abort_run("A byte that is not a command started a transmission");
        end
      end
    join
    compare_bit("o_led", o_led, 1'b1);
  endtask

  task automatic soft_reset_with_ack();
    byte_t ack;
    fork
      send_byte(`CMD_SOFT_RESET);
      receive_byte(ack);
    join
    compare_byte("ack byte", ack, `CMD_LOAD);
    @(negedge i_clock);
    compare_bit("o_led", o_led, 1'b0);  // Left the idle state.
  endtask

  task automatic test_continuous_run();
    mem_addr_t expected_pc;
    int        last;
    send_byte(`CMD_LOAD);
    load_program();
    last = program_words.size() - 1;
    fork
      send_byte(`CMD_RUN);
      begin
        wait_running(1'b1);
        expected_pc = '0;
        while (o_running === 1'b1) begin
          compare_addr("o_pc", o_pc, expected_pc);
          compare_instruction("o_instruction", o_instruction, program_words[expected_pc]);
          if (int'(expected_pc) >= last) begin
            abort_run("o_running stayed high past the halt word");
          end
          expected_pc++;
          @(negedge i_clock);
        end
      end
    join
    @(negedge i_clock);
    compare_addr("o_pc", o_pc, mem_addr_t'(last));  // Halt address.
    compare_bit("o_running", o_running, 1'b0);
  endtask

  task automatic test_step_run();
    int last;
    soft_reset_with_ack();
    send_byte(`CMD_LOAD);
    load_program();
    last = program_words.size() - 1;
    send_byte(BAD_START);
    check_not_running(QUIET_CYCLES);
    fork
      send_byte(`CMD_STEP_RUN);
      wait_running(1'b1);
    join
    @(negedge i_clock);
    compare_addr("o_pc", o_pc, '0);
    compare_instruction("o_instruction", o_instruction, program_words[0]);
    for (int i = 1; i <= last; i++) begin
      send_byte(STEP_BYTE);
      @(negedge i_clock);
      compare_addr("o_pc", o_pc, mem_addr_t'(i));
      compare_instruction("o_instruction", o_instruction, program_words[i]);
      compare_bit("o_running", o_running, i < last);
    end
  endtask

  initial begin
    i_reset   = 1'b0;
    i_uart_rx = 1'b1;
    void'($urandom(SEED));
    repeat (8) @(posedge i_clock);
    #1 i_reset = 1'b1;
    test_after_reset();
    test_idle_ignore();
    soft_reset_with_ack();
    test_continuous_run();
    test_step_run();
    $display("Test passed");
    $finish;
  end

endmodule

// File: test/mips_loader_asserts.sv
`timescale 1ns/1ps

module mips_loader_asserts
  import loader_pkg::*;
(
  input logic         i_clock,
  input logic         i_reset,
  input debug_state_t i_state,
  input logic         i_wr_en,
  input logic         i_tx_start
);

  a_state_onehot : assert property (@(posedge i_clock) disable iff (!i_reset)
    $onehot(i_state))
    else $error("debug state is not one-hot");

  // Writes only happen while loading.
  a_wr_in_load : assert property (@(posedge i_clock) disable iff (!i_reset)
    i_wr_en |-> (i_state == DBG_LOAD))
    else $error("memory write outside DBG_LOAD");

  a_tx_pulse : assert property (@(posedge i_clock) disable iff (!i_reset)
    i_tx_start |=> !i_tx_start)
    else $error("tx start held longer than one cycle");

endmodule

bind debug_unit mips_loader_asserts i_mips_loader_asserts (
  .i_clock    (i_clock),
  .i_reset    (i_reset),
  .i_state    (state),
  .i_wr_en    (o_wr_en),
  .i_tx_start (o_tx_start)
);

// File: design/mips_loader_top.sv
`timescale 1ns/1ps

module mips_loader_top
  import loader_pkg::*;
(
  input  logic         i_clock,
  input  logic         i_reset,
  input  logic         i_uart_rx,
  output logic         o_uart_tx,
  output logic         o_led,
  output mem_addr_t    o_pc,
  output instruction_t o_instruction,
  output logic         o_running
);

  byte_t        rx_data;
  logic         rx_valid;
  logic         tx_start;
  byte_t        tx_data;
  logic         wr_en;
  mem_addr_t    wr_addr;
  instruction_t wr_data;
  mem_addr_t    rd_addr;
  instruction_t rd_data;

  core_ctrl_if i_core_ctrl_if ();

  //////////////////////////////////////////////////////////////////////
  // Serial link.
  //////////////////////////////////////////////////////////////////////

  uart_rx i_uart_rx_0 (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_serial (i_uart_rx),
    .o_data   (rx_data),
    .o_valid  (rx_valid)
  );

  uart_tx i_uart_tx_0 (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_start  (tx_start),
    .i_data   (tx_data),
    .o_serial (o_uart_tx),
    .o_busy   ()  // Only one byte per soft reset.
  );

  //////////////////////////////////////////////////////////////////////
  // Debug control, program store and fetch.
  //////////////////////////////////////////////////////////////////////

  debug_unit i_debug_unit (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rx_data  (rx_data),
    .i_rx_valid (rx_valid),
    .o_tx_start (tx_start),
    .o_tx_data  (tx_data),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .core       (i_core_ctrl_if.debug),
    .o_led      (o_led)
  );

  program_memory i_program_memory (
    .i_clock   (i_clock),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  fetch_unit i_fetch_unit (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_step        (rx_valid),  // Each received byte is one step.
    .core          (i_core_ctrl_if.core),
    .o_rd_addr     (rd_addr),
    .i_rd_data     (rd_data),
    .o_pc          (o_pc),
    .o_instruction (o_instruction),
    .o_running     (o_running)
  );

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import loader_pkg::*;
(
  input  logic         i_clock,
  input  logic         i_reset,
  input  logic         i_step,
  core_ctrl_if.core    core,
  output mem_addr_t    o_rd_addr,
  input  instruction_t i_rd_data,
  output mem_addr_t    o_pc,
  output instruction_t o_instruction,
  output logic         o_running
);

  mem_addr_t pc_q;
  mem_addr_t pc_next;
  logic      valid_q;   // i_rd_data holds the word at pc_q.
  logic      halted_q;
  logic      ack_n_q;
  logic      at_halt;
  logic      advance;

  assign at_halt = valid_q && (i_rd_data == '0);

  // First fetch after a start is automatic in either mode.
  assign advance = core.run && !halted_q && !at_halt &&
                   (!valid_q || !core.step_mode || i_step);

  assign pc_next   = valid_q ? pc_q + 1'b1 : pc_q;
  assign o_rd_addr = advance ? pc_next : pc_q;  // Holding keeps data stable.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      pc_q     <= '0;
      valid_q  <= 1'b0;
      halted_q <= 1'b0;
      ack_n_q  <= 1'b1;
    end else if (!core.soft_reset_n) begin
      pc_q     <= '0;
      valid_q  <= 1'b0;
      halted_q <= 1'b0;
      ack_n_q  <= 1'b0;  // PC is clear from here on.
    end else begin
      ack_n_q <= 1'b1;
      if (advance) begin
        pc_q    <= pc_next;
        valid_q <= 1'b1;
      end
      if (core.run && at_halt) begin
        halted_q <= 1'b1;
      end
    end
  end

  assign core.soft_reset_ack_n = ack_n_q;
  assign o_pc                  = pc_q;
  assign o_instruction         = valid_q ? i_rd_data : '0;
  assign o_running             = core.run && valid_q && !halted_q && !at_halt;

endmodule

// File: design/program_memory.sv
`timescale 1ns/1ps
`include "loader_defs.svh"

module program_memory
  import loader_pkg::*;
(
  input  logic         i_clock,
  input  logic         i_wr_en,
  input  mem_addr_t    i_wr_addr,
  input  instruction_t i_wr_data,
  input  mem_addr_t    i_rd_addr,
  output instruction_t o_rd_data
);

  localparam int DEPTH = 2 ** `LOADER_ADDR_BITS;

  instruction_t mem [DEPTH];

  // Read returns old data on a same-address write.
  always_ff @(posedge i_clock) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

// File: design/debug_unit.sv
`timescale 1ns/1ps
`include "loader_defs.svh"

module debug_unit
  import loader_pkg::*;
(
  input  logic          i_clock,
  input  logic          i_reset,
  input  byte_t         i_rx_data,
  input  logic          i_rx_valid,
  output logic          o_tx_start,
  output byte_t         o_tx_data,
  output logic          o_wr_en,
  output mem_addr_t     o_wr_addr,
  output instruction_t  o_wr_data,
  core_ctrl_if.debug    core,
  output logic          o_led
);

  debug_state_t state;
  debug_state_t state_next;
  instruction_t instr_q;     // Word being assembled.
  logic [1:0]   byte_cnt_q;  // Bytes received in current word.
  mem_addr_t    addr_q;      // Next write address.
  logic         wr_en_q;
  logic         run_q;
  logic         step_q;
  logic         ack_seen;

  assign ack_seen = (state == DBG_SOFT_RESET) && !core.soft_reset_ack_n;

  //////////////////////////////////////////////////////////////////////
  // Next state.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      DBG_IDLE: begin
        if (i_rx_valid && i_rx_data == `CMD_SOFT_RESET) begin
          state_next = DBG_SOFT_RESET;
        end
      end
      DBG_SOFT_RESET: begin
        if (ack_seen) begin
          state_next = DBG_SEND_ACK;
        end
      end
      DBG_SEND_ACK: begin
        if (i_rx_valid && i_rx_data == `CMD_LOAD) begin
          state_next = DBG_LOAD;
        end
      end
      DBG_LOAD: begin
        if (wr_en_q && instr_q == '0) begin
          state_next = DBG_WAIT_START;  // Halt word is being written.
        end
      end
      DBG_WAIT_START: begin
        if (i_rx_valid &&
            (i_rx_data == `CMD_RUN || i_rx_data == `CMD_STEP_RUN)) begin
          state_next = DBG_IDLE;
        end
      end
      default: begin
        state_next = DBG_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State, word assembly and run control.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state      <= DBG_IDLE;
      byte_cnt_q <= '0;
      addr_q     <= '0;
      wr_en_q    <= 1'b0;
      run_q      <= 1'b0;
      step_q     <= 1'b0;
    end else begin
      state   <= state_next;
      wr_en_q <= 1'b0;
      if (state == DBG_LOAD) begin
        if (i_rx_valid) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
          if (byte_cnt_q == 2'd3) begin
            wr_en_q <= 1'b1;  // Write on the next cycle.
          end
        end
        if (wr_en_q) begin
          addr_q <= addr_q + 1'b1;
        end
      end else begin
        byte_cnt_q <= '0;  // Each load starts at word 0.
        addr_q     <= '0;
      end
      if (state == DBG_IDLE && state_next == DBG_SOFT_RESET) begin
        run_q <= 1'b0;
      end
      if (state == DBG_WAIT_START && state_next == DBG_IDLE) begin
        run_q  <= 1'b1;
        step_q <= i_rx_data[2];  // Bit 2 selects step mode.
      end
    end
  end

  // Bytes arrive MSB first.
  always_ff @(posedge i_clock) begin
    if (state == DBG_LOAD && i_rx_valid) begin
      instr_q <= {instr_q[`LOADER_INSTR_BITS-`LOADER_BYTE_BITS-1:0], i_rx_data};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs.
  //////////////////////////////////////////////////////////////////////

  assign o_tx_start        = ack_seen;  // Pulse on entry to DBG_SEND_ACK.
  assign o_tx_data         = `CMD_LOAD;
  assign o_wr_en           = wr_en_q;
  assign o_wr_addr         = addr_q;
  assign o_wr_data         = instr_q;
  assign core.soft_reset_n = (state != DBG_SOFT_RESET);
  assign core.run          = run_q;
  assign core.step_mode    = step_q;
  assign o_led             = (state == DBG_IDLE);

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "loader_defs.svh"

module uart_tx
  import loader_pkg::*;
(
  input  logic  i_clock,
  input  logic  i_reset,
  input  logic  i_start,
  input  byte_t i_data,
  output logic  o_serial,
  output logic  o_busy
);

  localparam int CLKS_PER_BIT = `LOADER_CLKS_PER_BIT;
  localparam int CNT_BITS     = $clog2(CLKS_PER_BIT);
  localparam int IDX_BITS     = $clog2(`LOADER_BYTE_BITS);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t           state;
  logic [CNT_BITS-1:0] clk_cnt;
  logic [IDX_BITS-1:0] bit_idx;
  logic                bit_end;
  logic                serial_q;
  byte_t               data_q;

  assign bit_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state    <= TX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      serial_q <= 1'b1;  // Line idles high.
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          clk_cnt  <= '0;
          bit_idx  <= '0;
          serial_q <= 1'b1;
          if (i_start) begin
            serial_q <= 1'b0;  // Start bit.
            state    <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            serial_q <= data_q[0];
            state    <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_BITS'(`LOADER_BYTE_BITS - 1)) begin
              serial_q <= 1'b1;  // Stop bit.
              state    <= TX_STOP;
            end else begin
              serial_q <= data_q[bit_idx + 1'b1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  // Byte is captured only when a frame begins.
  always_ff @(posedge i_clock) begin
    if (state == TX_IDLE && i_start) begin
      data_q <= i_data;
    end
  end

  assign o_serial = serial_q;
  assign o_busy   = (state != TX_IDLE);

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "loader_defs.svh"

module uart_rx
  import loader_pkg::*;
(
  input  logic  i_clock,
  input  logic  i_reset,
  input  logic  i_serial,
  output byte_t o_data,
  output logic  o_valid
);

  localparam int CLKS_PER_BIT = `LOADER_CLKS_PER_BIT;
  localparam int CNT_BITS     = $clog2(CLKS_PER_BIT);
  localparam int IDX_BITS     = $clog2(`LOADER_BYTE_BITS);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t           state;
  logic [CNT_BITS-1:0] clk_cnt;
  logic [IDX_BITS-1:0] bit_idx;
  logic                bit_end;
  logic                valid_q;
  byte_t               shift_q;

  // Later bits are sampled one full period after the start bit middle.
  assign bit_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // Strobe by default.
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!i_serial) begin
            state <= RX_START;  // Falling edge of start bit.
          end
        end
        RX_START: begin
          if (clk_cnt == CNT_BITS'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            state   <= i_serial ? RX_IDLE : RX_DATA;  // Drop glitches.
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_BITS'(`LOADER_BYTE_BITS - 1)) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            clk_cnt <= '0;
            valid_q <= i_serial;  // Good stop bit only.
            state   <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge i_clock) begin
    if (state == RX_DATA && bit_end) begin
      shift_q <= {i_serial, shift_q[`LOADER_BYTE_BITS-1:1]};
    end
  end

  assign o_data  = shift_q;
  assign o_valid = valid_q;

endmodule

// File: design/core_ctrl_if.sv
`timescale 1ns/1ps

interface core_ctrl_if;

  logic soft_reset_n;      // Active low.
  logic run;               // Start command seen.
  logic step_mode;         // One instruction per received byte.
  logic soft_reset_ack_n;  // Core has cleared its PC.

  modport debug (
    output soft_reset_n,
    output run,
    output step_mode,
    input  soft_reset_ack_n
  );

  modport core (
    input  soft_reset_n,
    input  run,
    input  step_mode,
    output soft_reset_ack_n
  );

endinterface

// File: design/loader_pkg.sv
`include "loader_defs.svh"

package loader_pkg;

  // One character on the serial line.
  typedef logic [`LOADER_BYTE_BITS-1:0] byte_t;

  // One instruction word, sent MSB first as four bytes.
  typedef logic [`LOADER_INSTR_BITS-1:0] instruction_t;

  // Program memory word address.
  typedef logic [`LOADER_ADDR_BITS-1:0] mem_addr_t;

  // Debug unit command FSM, one-hot.
  typedef enum logic [4:0] {
    DBG_IDLE       = 5'b00001,  // Waiting for soft-reset command.
    DBG_SOFT_RESET = 5'b00010,  // Core held in soft reset.
    DBG_SEND_ACK   = 5'b00100,  // Ack sent, waiting for load command.
    DBG_LOAD       = 5'b01000,  // Receiving program bytes.
    DBG_WAIT_START = 5'b10000   // Waiting for a start command.
  } debug_state_t;

endpackage

// File: include/loader_defs.svh
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Data widths.
//////////////////////////////////////////////////////////////////////

`define LOADER_BYTE_BITS     8   // One UART character.
`define LOADER_INSTR_BITS    32  // One instruction word.
`define LOADER_ADDR_BITS     8   // Program memory word address.

//////////////////////////////////////////////////////////////////////
// UART timing and host command codes.
//////////////////////////////////////////////////////////////////////

`define LOADER_CLKS_PER_BIT  16  // Clock cycles per bit.

`define CMD_SOFT_RESET       8'h00  // Hold the core in soft reset.
`define CMD_LOAD             8'h01  // Start loading, also the ack byte.
`define CMD_RUN              8'h03  // Continuous mode.
`define CMD_STEP_RUN         8'h07  // Step mode, bit 2 set.

`endif
